/* Bender.yml */
package:
  name: alu_issue_cluster

sources:
  - include_dirs:
      - common
    files:
      - common/alu_pkg.sv
      - common/rs_pkg.sv
      - rs_alu/rs_slot_alloc.sv
      - rs_alu/rs_issue_select.sv
      - rs_alu/rs_alu_station.sv
      - hw/phys_regfile.sv
      - hw/alu_exec.sv
      - hw/alu_issue_cluster.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/tb_alu_issue_cluster.sv

/* common/alu_pkg.sv */
`include "rs_defs.svh"

package alu_pkg;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // One result broadcast, used for wakeup and register write.
  typedef struct packed {
    logic                  valid;
    logic [`PHY_TAG_W-1:0] tag;
    logic [`XLEN-1:0]      data;
  } wb_bus_t;

  typedef struct packed {
    logic                  valid;
    logic [31:0]           inst_num;
    logic [31:0]           pc;
    logic [`PHY_TAG_W-1:0] dest;
    logic [`XLEN-1:0]      data;
  } alu_result_t;

endpackage

/* common/rs_defs.svh */
`ifndef RS_DEFS_SVH
`define RS_DEFS_SVH

`define RS_DEPTH 16 // Station slots.

`define PHY_TAG_W 8 // 256 physical registers.

`define XLEN 32

`define NUM_EXT_WB 4 // Mul, div, load, branch/CSR.

`endif

/* common/rs_pkg.sv */
`include "rs_defs.svh"

package rs_pkg;

  typedef struct packed {
    logic [31:0]           inst_num;
    logic [31:0]           pc;
    logic [31:0]           imm;
    logic [`PHY_TAG_W-1:0] dest;
    alu_pkg::alu_op_e      op;
    logic                  src1_is_pc;
    logic                  src2_is_imm;
    logic [`PHY_TAG_W-1:0] src1_tag;
    logic [`PHY_TAG_W-1:0] src2_tag;
    logic                  src1_rdy;
    logic                  src2_rdy;
  } dispatch_t;

  typedef struct packed {
    logic      busy;
    dispatch_t ins; // Ready bits change in place.
  } rs_entry_t;

  // Operation handed to the ALU.
  typedef struct packed {
    logic                  valid;
    logic [31:0]           inst_num;
    logic [31:0]           pc;
    logic [31:0]           imm;
    logic [`PHY_TAG_W-1:0] dest;
    alu_pkg::alu_op_e      op;
    logic                  src1_is_pc;
    logic                  src2_is_imm;
    logic [`PHY_TAG_W-1:0] src1_tag;
    logic [`PHY_TAG_W-1:0] src2_tag;
  } issue_t;

endpackage

/* hw/alu_exec.sv */
`timescale 1ns/1ps
`include "rs_defs.svh"

module alu_exec (
  input  logic                 clk,
  input  logic                 rst_n,
  input  rs_pkg::issue_t       issue,
  input  logic [`XLEN-1:0]     rs1_data,
  input  logic [`XLEN-1:0]     rs2_data,
  output alu_pkg::alu_result_t alu_wb
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [4:0]       shamt;
  logic [`XLEN-1:0] result;

  assign op_a  = issue.src1_is_pc ? issue.pc : rs1_data; // AUIPC style.
  assign op_b  = issue.src2_is_imm ? issue.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (issue.op)
      alu_pkg::ALU_ADD:  result = op_a + op_b;
      alu_pkg::ALU_SUB:  result = op_a - op_b;
      alu_pkg::ALU_SLL:  result = op_a << shamt;
      alu_pkg::ALU_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_pkg::ALU_SLTU: result = {{(`XLEN-1){1'b0}}, op_a < op_b};
      alu_pkg::ALU_XOR:  result = op_a ^ op_b;
      alu_pkg::ALU_SRL:  result = op_a >> shamt;
      alu_pkg::ALU_SRA:  result = $unsigned($signed(op_a) >>> shamt);
      alu_pkg::ALU_OR:   result = op_a | op_b;
      alu_pkg::ALU_AND:  result = op_a & op_b;
      default:           result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    alu_wb.inst_num <= issue.inst_num;
    alu_wb.pc       <= issue.pc;
    alu_wb.dest     <= issue.dest;
    alu_wb.data     <= result;
    if (!rst_n) begin
      alu_wb.valid <= 1'b0;
    end else begin
      alu_wb.valid <= issue.valid; // One cycle after issue.
    end
  end

endmodule

/* hw/alu_issue_cluster.sv */
`timescale 1ns/1ps
`include "rs_defs.svh"

module alu_issue_cluster (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 dispatch_valid,
  input  rs_pkg::dispatch_t    disp,
  input  alu_pkg::wb_bus_t     ext_wb [`NUM_EXT_WB],
  input  logic                 flush,
  output logic                 full,
  output alu_pkg::alu_result_t alu_wb
);

  alu_pkg::wb_bus_t wake [`NUM_EXT_WB+1];
  alu_pkg::wb_bus_t alu_bus;
  rs_pkg::issue_t   issue;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;

  assign alu_bus.valid = alu_wb.valid;
  assign alu_bus.tag   = alu_wb.dest;
  assign alu_bus.data  = alu_wb.data;

  // ALU broadcast rides on the last bus.
  always_comb begin
    for (int b = 0; b < `NUM_EXT_WB; b++) begin
      wake[b] = ext_wb[b];
    end
    wake[`NUM_EXT_WB] = alu_bus;
  end

  rs_alu_station u_station (
    .clk            (clk),
    .rst_n          (rst_n),
    .dispatch_valid (dispatch_valid),
    .disp           (disp),
    .flush          (flush),
    .wake           (wake),
    .full           (full),
    .issue          (issue)
  );

  phys_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_tag1  (issue.src1_tag),
    .rd_tag2  (issue.src2_tag),
    .rd_data1 (rs1_data),
    .rd_data2 (rs2_data),
    .wr       (wake)
  );

  alu_exec u_alu (
    .clk      (clk),
    .rst_n    (rst_n),
    .issue    (issue),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .alu_wb   (alu_wb)
  );

endmodule

/* hw/phys_regfile.sv */
`timescale 1ns/1ps
`include "rs_defs.svh"

module phys_regfile (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`PHY_TAG_W-1:0] rd_tag1,
  input  logic [`PHY_TAG_W-1:0] rd_tag2,
  output logic [`XLEN-1:0]      rd_data1,
  output logic [`XLEN-1:0]      rd_data2,
  input  alu_pkg::wb_bus_t      wr [`NUM_EXT_WB+1]
);

  localparam int NUM_REGS = 1 << `PHY_TAG_W;
  localparam int NUM_WR   = `NUM_EXT_WB + 1;

  logic [`XLEN-1:0] regs [NUM_REGS];
  logic             dup_tag;

  assign rd_data1 = regs[rd_tag1];
  assign rd_data2 = regs[rd_tag2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int b = 0; b < NUM_WR; b++) begin
        if (wr[b].valid) begin
          regs[wr[b].tag] <= wr[b].data;
        end
      end
    end
  end

  always_comb begin
    dup_tag = 1'b0;
    for (int a = 0; a < NUM_WR; a++) begin
      for (int b = a + 1; b < NUM_WR; b++) begin
        dup_tag |= wr[a].valid && wr[b].valid && (wr[a].tag == wr[b].tag);
      end
    end
  end

  // Rename hands each tag to one producer, so writers never collide.
  a_unique_write_tag: assert property (
    @(posedge clk) disable iff (!rst_n) !dup_tag
  ) else $error("two write-back buses target the same physical register");

endmodule

/* rs_alu/rs_alu_station.sv */
`timescale 1ns/1ps
`include "rs_defs.svh"

module rs_alu_station (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                dispatch_valid,
  input  rs_pkg::dispatch_t   disp,
  input  logic                flush,
  input  alu_pkg::wb_bus_t    wake [`NUM_EXT_WB+1],
  output logic                full,
  output rs_pkg::issue_t      issue
);

  localparam int IDX_W = $clog2(`RS_DEPTH);

  rs_pkg::rs_entry_t       entries [`RS_DEPTH];
  logic [`RS_DEPTH-1:0]    busy;
  logic [`RS_DEPTH-1:0]    ready;
  logic [`RS_DEPTH-1:0]    grant;
  logic [IDX_W-1:0]        grant_idx;
  logic [IDX_W-1:0]        alloc_slot;
  logic                    any_ready;
  logic                    take;

  // True when any valid broadcast this cycle carries the tag.
  function automatic logic woken(input logic [`PHY_TAG_W-1:0] tag);
    logic hit;
    hit = 1'b0;
    for (int b = 0; b < `NUM_EXT_WB + 1; b++) begin
      hit |= wake[b].valid && (wake[b].tag == tag);
    end
    return hit;
  endfunction

  always_comb begin
    for (int i = 0; i < `RS_DEPTH; i++) begin
      busy[i]  = entries[i].busy;
      ready[i] = entries[i].busy && entries[i].ins.src1_rdy && entries[i].ins.src2_rdy;
    end
  end

  assign take = dispatch_valid && !full && !flush;

  rs_slot_alloc u_slot_alloc (
    .busy (busy),
    .slot (alloc_slot),
    .full (full)
  );

  rs_issue_select u_issue_select (
    .ready     (ready),
    .grant     (grant),
    .grant_idx (grant_idx),
    .any       (any_ready)
  );

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      for (int i = 0; i < `RS_DEPTH; i++) begin
        entries[i].busy <= 1'b0;
      end
    end else begin
      for (int i = 0; i < `RS_DEPTH; i++) begin
        if (entries[i].busy) begin
          entries[i].ins.src1_rdy <= entries[i].ins.src1_rdy | woken(entries[i].ins.src1_tag);
          entries[i].ins.src2_rdy <= entries[i].ins.src2_rdy | woken(entries[i].ins.src2_tag);
        end
        if (grant[i]) begin
          entries[i].busy <= 1'b0; // Leaves with this edge.
        end
      end
      if (take) begin
        entries[alloc_slot].busy         <= 1'b1;
        entries[alloc_slot].ins          <= disp;
        entries[alloc_slot].ins.src1_rdy <= disp.src1_rdy | woken(disp.src1_tag);
        entries[alloc_slot].ins.src2_rdy <= disp.src2_rdy | woken(disp.src2_tag);
      end
    end
  end

  always_comb begin
    issue.valid       = any_ready;
    issue.inst_num    = entries[grant_idx].ins.inst_num;
    issue.pc          = entries[grant_idx].ins.pc;
    issue.imm         = entries[grant_idx].ins.imm;
    issue.dest        = entries[grant_idx].ins.dest;
    issue.op          = entries[grant_idx].ins.op;
    issue.src1_is_pc  = entries[grant_idx].ins.src1_is_pc;
    issue.src2_is_imm = entries[grant_idx].ins.src2_is_imm;
    issue.src1_tag    = entries[grant_idx].ins.src1_tag;
    issue.src2_tag    = entries[grant_idx].ins.src2_tag;
  end

  // Rename must hold dispatch while the station reports full.
  a_no_dispatch_when_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    dispatch_valid && !flush |-> !full
  ) else $error("dispatch while station full, instruction %0d dropped", disp.inst_num);

endmodule

/* rs_alu/rs_issue_select.sv */
`timescale 1ns/1ps
`include "rs_defs.svh"

module rs_issue_select (
  input  logic [`RS_DEPTH-1:0]         ready,
  output logic [`RS_DEPTH-1:0]         grant,
  output logic [$clog2(`RS_DEPTH)-1:0] grant_idx,
  output logic                         any
);

  localparam int IDX_W = $clog2(`RS_DEPTH);

  assign grant = ready & (~ready + 1'b1); // Isolate lowest set bit.
  assign any   = |ready;

  always_comb begin
    grant_idx = '0;
    for (int i = 0; i < `RS_DEPTH; i++) begin
      if (grant[i]) begin
        grant_idx = IDX_W'(i);
      end
    end
  end

endmodule

/* rs_alu/rs_slot_alloc.sv */
`timescale 1ns/1ps
`include "rs_defs.svh"

module rs_slot_alloc (
  input  logic [`RS_DEPTH-1:0]         busy,
  output logic [$clog2(`RS_DEPTH)-1:0] slot,
  output logic                         full
);

  localparam int IDX_W = $clog2(`RS_DEPTH);

  // Scan downward so the lowest free index is the last one written.
  always_comb begin
    slot = '0;
    for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        slot = IDX_W'(i);
      end
    end
  end

  assign full = &busy;

endmodule

/* verification/alu_issue_testdata.txt */
# W bus tag data | D inst pc imm dest op s1pc s2imm s1tag s2tag s1rdy s2rdy expected
# F flush | I idle_cycles (bus and idle in decimal, the rest in hex; op 0 add .. 9 and)
W 0 10 00000007
W 1 11 fffffff0
W 2 12 00000003
W 3 13 80000000
I 2
D 01 00001000 00000000 20 0 0 0 10 11 1 1 fffffff7
D 02 00001004 00000000 21 1 0 0 10 11 1 1 00000017
D 03 00001008 00000000 22 2 0 0 10 12 1 1 00000038
D 04 0000100c 00000000 23 3 0 0 11 10 1 1 00000001
D 05 00001010 00000000 24 4 0 0 11 10 1 1 00000000
D 06 00001014 00000000 25 5 0 0 10 11 1 1 fffffff7
D 07 00001018 00000000 26 6 0 0 13 12 1 1 10000000
D 08 0000101c 00000000 27 7 0 0 13 12 1 1 f0000000
D 09 00001020 00000000 28 8 0 0 10 12 1 1 00000007
D 0a 00001024 00000000 29 9 0 0 11 13 1 1 80000000
D 0b 00002000 00000100 2b 0 1 1 00 00 1 1 00002100
D 0c 00001030 00000020 2c 0 0 1 11 00 1 1 00000010
D 0d 00001034 00000023 2d 2 0 1 10 00 1 1 00000038
I 4
D 10 00003000 00000000 40 0 0 0 30 10 0 1 00000107
I 5
W 0 30 00000100
I 1
W 1 31 00000050
D 11 00003004 00000000 41 0 0 0 31 10 0 1 00000057
I 4
D 20 00004000 00000001 50 0 0 1 32 00 0 1 00000008
D 21 00004004 00000000 51 0 0 0 50 10 0 1 0000000f
D 22 00004008 00000000 52 0 0 0 51 51 0 0 0000001e
D 23 0000400c 00000000 53 1 0 0 52 12 0 1 0000001b
I 1
W 0 32 00000007
I 12
D 30 00005000 00000000 70 0 0 1 60 00 0 1 00001000
D 31 00005004 00000001 71 0 0 1 60 00 0 1 00001001
D 32 00005008 00000002 72 0 0 1 60 00 0 1 00001002
D 33 0000500c 00000003 73 0 0 1 60 00 0 1 00001003
D 34 00005010 00000004 74 0 0 1 60 00 0 1 00001004
D 35 00005014 00000005 75 0 0 1 60 00 0 1 00001005
D 36 00005018 00000006 76 0 0 1 60 00 0 1 00001006
D 37 0000501c 00000007 77 0 0 1 60 00 0 1 00001007
D 38 00005020 00000008 78 0 0 1 60 00 0 1 00001008
D 39 00005024 00000009 79 0 0 1 60 00 0 1 00001009
D 3a 00005028 0000000a 7a 0 0 1 60 00 0 1 0000100a
D 3b 0000502c 0000000b 7b 0 0 1 60 00 0 1 0000100b
D 3c 00005030 0000000c 7c 0 0 1 60 00 0 1 0000100c
D 3d 00005034 0000000d 7d 0 0 1 60 00 0 1 0000100d
D 3e 00005038 0000000e 7e 0 0 1 60 00 0 1 0000100e
D 3f 0000503c 0000000f 7f 0 0 1 60 00 0 1 0000100f
I 2
W 0 60 00001000
I 20
D 40 00006000 00000001 91 0 0 1 90 00 0 1 00000006
D 41 00006004 00000002 93 0 0 1 90 00 0 1 00000007
I 3
F
W 0 90 00000005
I 1
D 42 00006008 00000001 92 0 0 1 90 00 1 1 00000006
I 5

/* verification/tb_alu_issue_cluster.sv */
`timescale 1ns/1ps
`include "rs_defs.svh"

module tb_alu_issue_cluster;

  localparam int WAIT_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 500;

  logic                 clk;
  logic                 rst_n;
  logic                 dispatch_valid;
  rs_pkg::dispatch_t    disp;
  alu_pkg::wb_bus_t     ext_wb [`NUM_EXT_WB];
  logic                 flush;
  logic                 full;
  alu_pkg::alu_result_t alu_wb;

  alu_pkg::wb_bus_t     staged [`NUM_EXT_WB]; // Writes that go out with the next step.
  alu_pkg::alu_result_t exp_res [int];
  int                   wait1 [int];
  int                   wait2 [int];
  bit                   flushed [int];
  bit                   tag_written [1 << `PHY_TAG_W];
  int                   errors;
  int                   tests;
  int                   failed_tests;

  alu_issue_cluster u_alu_issue_cluster (
    .clk            (clk),
    .rst_n          (rst_n),
    .dispatch_valid (dispatch_valid),
    .disp           (disp),
    .ext_wb         (ext_wb),
    .flush          (flush),
    .full           (full),
    .alu_wb         (alu_wb)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_result(input alu_pkg::alu_result_t exp,
                              input alu_pkg::alu_result_t act, output bit ok);
    ok = 1'b1;
    if (act.inst_num !== exp.inst_num) begin
      $display("[FAIL] %0t alu_wb.inst_num expected %h actual %h", $time, exp.inst_num,
               act.inst_num);
      ok = 1'b0;
    end
    if (act.pc !== exp.pc) begin
      $display("[FAIL] %0t alu_wb.pc expected %h actual %h", $time, exp.pc, act.pc);
      ok = 1'b0;
    end
    if (act.dest !== exp.dest) begin
      $display("[FAIL] %0t alu_wb.dest expected %h actual %h", $time, exp.dest, act.dest);
      ok = 1'b0;
    end
    if (act.data !== exp.data) begin
      $display("[FAIL] %0t alu_wb.data expected %h actual %h", $time, exp.data, act.data);
      ok = 1'b0;
    end
    if (!ok) errors++;
  endtask

  task automatic check_full(input logic exp, input logic act, output bit ok);
    ok = (act === exp);
    if (!ok) begin
      $display("[FAIL] %0t full expected %b actual %b", $time, exp, act);
      errors++;
    end
  endtask

  // One clock of stimulus, held until the next call.
  task automatic drive_cycle(input logic dv, input rs_pkg::dispatch_t d, input logic fl,
                             input bit use_staged);
    @(posedge clk);
    dispatch_valid <= dv;
    disp           <= d;
    flush          <= fl;
    for (int b = 0; b < `NUM_EXT_WB; b++) begin
      if (use_staged) begin
        ext_wb[b] <= staged[b];
        if (staged[b].valid) tag_written[staged[b].tag] = 1'b1;
        staged[b] = '0;
      end else begin
        ext_wb[b] <= '0;
      end
    end
  endtask

  // A dispatch still on the pins is not yet in full, so wait for a quiet cycle.
  task automatic wait_not_full(output bit ok);
    ok = 1'b0;
    for (int n = 0; n < WAIT_LIMIT; n++) begin
      @(negedge clk);
      if (!full && !dispatch_valid) begin
        ok = 1'b1;
        break;
      end
      drive_cycle(1'b0, '0, 1'b0, 1'b0);
    end
    if (!ok) begin
      $display("timeout after %0d cycles waiting for full to fall", WAIT_LIMIT);
      errors++;
    end
  endtask

  function automatic int blocked_count();
    int n;
    n = 0;
    foreach (exp_res[k]) begin
      if ((wait1[k] >= 0 && !tag_written[wait1[k]]) ||
          (wait2[k] >= 0 && !tag_written[wait2[k]])) n++;
    end
    return n;
  endfunction

  always @(negedge clk) begin : result_monitor
    int k;
    bit ok;
    if (rst_n && alu_wb.valid === 1'b1) begin
      k = int'(alu_wb.inst_num);
      tag_written[alu_wb.dest] = 1'b1;
      tests++;
      if (flushed.exists(k)) begin
        $display("flushed instruction %0d appeared on alu_wb at %0t", k, $time);
        errors++;
        failed_tests++;
      end else if (!exp_res.exists(k)) begin
        $display("unexpected result for instruction %0d at %0t", k, $time);
        errors++;
        failed_tests++;
      end else begin
        check_result(exp_res[k], alu_wb, ok);
        if ((wait1[k] >= 0 && !tag_written[wait1[k]]) ||
            (wait2[k] >= 0 && !tag_written[wait2[k]])) begin
          $display("instruction %0d completed before its source tag was written", k);
          errors++;
          ok = 1'b0;
        end
        if (!ok) failed_tests++;
        $display("test inst %0d result %s", k, ok ? "ok" : "wrong");
        exp_res.delete(k);
        wait1.delete(k);
        wait2.delete(k);
      end
    end
  end

  initial begin : stimulus
    int                   fd;
    int                   code;
    int                   cnt;
    int                   bus;
    byte                  cmd;
    string                line;
    bit                   ok;
    logic [31:0]          fld [12];
    rs_pkg::dispatch_t    d;
    alu_pkg::alu_result_t er;
    void'($urandom(95005));
    errors         = 0;
    tests          = 0;
    failed_tests   = 0;
    rst_n          <= 1'b0;
    dispatch_valid <= 1'b0;
    disp           <= '0;
    flush          <= 1'b0;
    for (int b = 0; b < `NUM_EXT_WB; b++) begin
      ext_wb[b] <= '0;
      staged[b] = '0;
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    fd = $fopen("verification/alu_issue_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test data file");
      errors++;
    end else begin
      while ($fscanf(fd, " %c", cmd) == 1) begin
        case (cmd)
          "#": code = $fgets(line, fd);
          "W": begin
            code = $fscanf(fd, "%d %h %h", bus, fld[0], fld[1]);
            if (code != 3 || bus >= `NUM_EXT_WB) begin
              $display("malformed write-back line in test data");
              errors++;
              break;
            end
            staged[bus].valid = 1'b1;
            staged[bus].tag   = fld[0][`PHY_TAG_W-1:0];
            staged[bus].data  = fld[1];
          end
          "D": begin
            code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h", fld[0], fld[1],
                           fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8], fld[9],
                           fld[10], fld[11]);
            if (code != 12) begin
              $display("malformed dispatch line in test data");
              errors++;
              break;
            end
            d.inst_num    = fld[0];
            d.pc          = fld[1];
            d.imm         = fld[2];
            d.dest        = fld[3][`PHY_TAG_W-1:0];
            d.op          = alu_pkg::alu_op_e'(fld[4][3:0]);
            d.src1_is_pc  = fld[5][0];
            d.src2_is_imm = fld[6][0];
            d.src1_tag    = fld[7][`PHY_TAG_W-1:0];
            d.src2_tag    = fld[8][`PHY_TAG_W-1:0];
            d.src1_rdy    = fld[9][0];
            d.src2_rdy    = fld[10][0];
            wait_not_full(ok);
            if (!ok) break;
            drive_cycle(1'b1, d, 1'b0, 1'b1);
            er.valid    = 1'b1;
            er.inst_num = d.inst_num;
            er.pc       = d.pc;
            er.dest     = d.dest;
            er.data     = fld[11];
            exp_res[int'(d.inst_num)] = er;
            wait1[int'(d.inst_num)]   = d.src1_rdy ? -1 : int'(d.src1_tag);
            wait2[int'(d.inst_num)]   = d.src2_rdy ? -1 : int'(d.src2_tag);
            if (blocked_count() == `RS_DEPTH) begin // Every slot holds a stuck entry.
              drive_cycle(1'b0, '0, 1'b0, 1'b0);
              @(negedge clk);
              check_full(1'b1, full, ok);
              tests++;
              if (!ok) failed_tests++;
              $display("test full raised %s", ok ? "ok" : "wrong");
            end
          end
          "F": begin
            drive_cycle(1'b0, '0, 1'b1, 1'b1);
            foreach (exp_res[k]) flushed[k] = 1'b1;
            exp_res.delete();
            wait1.delete();
            wait2.delete();
          end
          "I": begin
            code = $fscanf(fd, "%d", cnt);
            if (code != 1) begin
              $display("malformed idle line in test data");
              errors++;
              break;
            end
            cnt = cnt + int'($urandom % 4);
            repeat (cnt) drive_cycle(1'b0, '0, 1'b0, 1'b1);
          end
          default: begin
            $display("unknown command %c in test data", cmd);
            errors++;
            break;
          end
        endcase
      end
      $fclose(fd);
    end
    ok = 1'b0;
    for (int n = 0; n < DRAIN_LIMIT; n++) begin
      drive_cycle(1'b0, '0, 1'b0, 1'b1);
      @(negedge clk);
      if (exp_res.num() == 0) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) begin
      $display("timeout with %0d results still outstanding", exp_res.num());
      errors++;
    end
    repeat (10) drive_cycle(1'b0, '0, 1'b0, 1'b1); // Room for a stray flushed result.
    @(negedge clk);
    check_full(1'b0, full, ok);
    tests++;
    if (!ok) failed_tests++;
    $display("test full fallen %s", ok ? "ok" : "wrong");
    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+common
common/alu_pkg.sv
common/rs_pkg.sv
rs_alu/rs_slot_alloc.sv
rs_alu/rs_issue_select.sv
rs_alu/rs_alu_station.sv
hw/phys_regfile.sv
hw/alu_exec.sv
hw/alu_issue_cluster.sv
verification/tb_alu_issue_cluster.sv
